// ==== sim.f ====
+incdir+bench
design/cpu_arch_pkg.sv
design/wb_port_pkg.sv
design/pc_sequencer.sv
design/exception_entry.sv
design/banked_register_file.sv
design/writeback_unit.sv
bench/writeback_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= writeback_tb
RTL_TOP   ?= writeback_unit
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TEST RESULT: PASS

RTL_SRCS = design/cpu_arch_pkg.sv design/wb_port_pkg.sv design/pc_sequencer.sv \
           design/exception_entry.sv design/banked_register_file.sv design/writeback_unit.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/writeback_vectors.svh ====
`ifndef WRITEBACK_VECTORS_SVH
`define WRITEBACK_VECTORS_SVH

// Columns: stall, alu clear, alu target, exception bits, write request, PC+8,
// read indices, expected PC, expected CPSR, expected read data, read select,
// expected flush, FIQ ack and IRQ ack.
// Read select per port: 0 literal, 1 random word of port 0, 2 random word of port 1.
row_t rows [NUM_ROWS] = '{
        // Free running from reset.
        '{5'h00, 1'b0, 32'h0, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h4, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        '{5'h00, 1'b0, 32'h0, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h8, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        // Code, data, decode, issue and shifter stalls in turn.
        '{5'h10, 1'b0, 32'h0, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h8, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        '{5'h08, 1'b0, 32'h0, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h8, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        '{5'h04, 1'b0, 32'h0, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h8, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        '{5'h02, 1'b0, 32'h0, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h8, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        '{5'h01, 1'b0, 32'h0, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h8, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        // Clear beats a decode stall, a code stall beats the clear.
        '{5'h04, 1'b1, 32'h100, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h100, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        '{5'h10, 1'b1, 32'h200, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h100, 32'h13, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        // PC write to an odd address enters Thumb state.
        '{5'h00, 1'b0, 32'h0, 6'h00,
          '{1'b1, 6'd15, 32'h301, 6'd37, 32'h12345678, 1'b0, 4'h0, 1'b0}, 32'h0,
          '{6'd15, 6'd16, 6'd37, 6'd0}, 32'h301, 32'h33,
          '{32'h301, 32'h33, 32'h12345678, 32'h0}, 8'h00, 1'b1, 1'b0, 1'b0},
        '{5'h00, 1'b0, 32'h0, 6'h00, '0, 32'h0,
          '{6'd0, 6'd1, 6'd2, 6'd3}, 32'h303, 32'h33, '0, 8'h00, 1'b0, 1'b0, 1'b0},
        // Random data on both ports, then a same-index collision.
        '{5'h00, 1'b0, 32'h0, 6'h00,
          '{1'b1, 6'd1, 32'h0, 6'd2, 32'h0, 1'b1, 4'ha, 1'b0}, 32'h0,
          '{6'd1, 6'd2, 6'd1, 6'd2}, 32'h305, 32'ha0000033, '0, 8'b01_10_01_10,
          1'b0, 1'b0, 1'b0},
        '{5'h00, 1'b0, 32'h0, 6'h00,
          '{1'b1, 6'd3, 32'h0, 6'd3, 32'h0, 1'b1, 4'h5, 1'b0}, 32'h0,
          '{6'd3, 6'd0, 6'd3, 6'd0}, 32'h307, 32'h50000033, '0, 8'b10_00_10_00,
          1'b0, 1'b0, 1'b0},
        // IRQ over SWI and undefined, under a code stall.
        '{5'h10, 1'b0, 32'h0, 6'b001011, '0, 32'h400,
          '{6'd25, 6'd33, 6'd16, 6'd15}, 32'h18, 32'h50000032,
          '{32'h3fc, 32'h50000033, 32'h50000032, 32'h18}, 8'h00, 1'b1, 1'b0, 1'b1},
        // FIQ over instruction abort and undefined.
        '{5'h00, 1'b0, 32'h0, 6'b010101, '0, 32'h500,
          '{6'd23, 6'd32, 6'd16, 6'd15}, 32'h1c, 32'h50000031,
          '{32'h4fc, 32'h50000032, 32'h50000031, 32'h1c}, 8'h00, 1'b1, 1'b1, 1'b0},
        // Data abort over FIQ.
        '{5'h00, 1'b0, 32'h0, 6'b110000, '0, 32'h600,
          '{6'd29, 6'd35, 6'd16, 6'd15}, 32'h10, 32'h50000037,
          '{32'h600, 32'h50000031, 32'h50000037, 32'h10}, 8'h00, 1'b1, 1'b0, 1'b0},
        // Privileged control byte change.
        '{5'h00, 1'b0, 32'h0, 6'h00,
          '{1'b1, 6'd37, 32'h0, 6'd16, 32'hd3, 1'b0, 4'h3, 1'b0}, 32'h700,
          '{6'd16, 6'd15, 6'd37, 6'd0}, 32'h6fc, 32'hd3,
          '{32'hd3, 32'h6fc, 32'h0, 32'h0}, 8'h00, 1'b1, 1'b0, 1'b0},
        // Load the SVC SPSR, then return through it.
        '{5'h00, 1'b0, 32'h0, 6'h00,
          '{1'b1, 6'd38, 32'h0, 6'd34, 32'h80000010, 1'b0, 4'h0, 1'b0}, 32'h0,
          '{6'd34, 6'd16, 6'd15, 6'd0}, 32'h700, 32'hd3,
          '{32'h80000010, 32'hd3, 32'h700, 32'h0}, 8'h00, 1'b0, 1'b0, 1'b0},
        '{5'h00, 1'b0, 32'h0, 6'h00,
          '{1'b1, 6'd15, 32'h800, 6'd39, 32'h0, 1'b0, 4'h0, 1'b1}, 32'h0,
          '{6'd15, 6'd16, 6'd34, 6'd0}, 32'h800, 32'h80000010,
          '{32'h800, 32'h80000010, 32'h80000010, 32'h0}, 8'h00, 1'b1, 1'b0, 1'b0},
        // User mode keeps the control byte.
        '{5'h00, 1'b0, 32'h0, 6'h00,
          '{1'b1, 6'd40, 32'h0, 6'd16, 32'hd3, 1'b0, 4'h0, 1'b0}, 32'h0,
          '{6'd16, 6'd15, 6'd0, 6'd0}, 32'h804, 32'h10,
          '{32'h10, 32'h804, 32'h0, 32'h0}, 8'h00, 1'b0, 1'b0, 1'b0}
};

`endif

// ==== bench/writeback_tb.sv ====
module writeback_tb;
        timeunit 1ns;
        timeprecision 1ps;

        import cpu_arch_pkg::*;
        import wb_port_pkg::*;

        localparam int NUM_ROWS     = 20;
        localparam int RESET_CYCLES = 4;
        localparam int CYCLE_LIMIT  = NUM_ROWS + RESET_CYCLES + 20;

        typedef struct packed {
                logic        valid;
                logic [5:0]  index_0;
                logic [31:0] data_0;
                logic [5:0]  index_1;
                logic [31:0] data_1;
                logic        rnd;
                logic [3:0]  flags;
                logic        flag_update;
        } wr_row_t;

        typedef struct packed {
                logic [4:0]        stall;
                logic              clear;
                logic [31:0]       alu_pc;
                logic [5:0]        exc;
                wr_row_t           wr;
                logic [31:0]       pc_buf;
                logic [0:3][5:0]   rd_index;
                logic [31:0]       exp_pc;
                logic [31:0]       exp_cpsr;
                logic [0:3][31:0]  exp_rd;
                logic [0:3][1:0]   rd_sel;
                logic              exp_flush;
                logic              exp_fiq;
                logic              exp_irq;
        } row_t;

`include "writeback_vectors.svh"

        logic          clk;
        logic          reset;
        stall_t        stall;
        logic          alu_clear;
        logic [31:0]   alu_pc;
        exc_req_t      exc;
        vector_table_t vectors;
        wr_req_t       wr;
        logic [31:0]   pc_buf;
        phy_reg_t      rd_index [4];
        logic [31:0]   rd_data [4];
        logic [31:0]   pc;
        cpsr_t         cpsr;
        logic          flush;
        logic          fiq_ack;
        logic          irq_ack;

        int            seed = 32'h6d074c38;
        int            cycles = 0;
        logic [31:0]   rand_0;
        logic [31:0]   rand_1;

        writeback_unit #(
                .PHY_REGS (MIN_PHY_REGS)
        ) i_writeback_unit (
                .i_clk                  (clk),
                .i_reset                (reset),
                .i_stall                (stall),
                .i_alu_clear            (alu_clear),
                .i_alu_pc               (alu_pc),
                .i_exc                  (exc),
                .i_vectors              (vectors),
                .i_wr                   (wr),
                .i_pc_buf               (pc_buf),
                .i_rd_index_0           (rd_index[0]),
                .i_rd_index_1           (rd_index[1]),
                .i_rd_index_2           (rd_index[2]),
                .i_rd_index_3           (rd_index[3]),
                .o_rd_data_0            (rd_data[0]),
                .o_rd_data_1            (rd_data[1]),
                .o_rd_data_2            (rd_data[2]),
                .o_rd_data_3            (rd_data[3]),
                .o_pc                   (pc),
                .o_cpsr                 (cpsr),
                .o_clear_from_writeback (flush),
                .o_fiq_ack              (fiq_ack),
                .o_irq_ack              (irq_ack)
        );

        initial
        begin
                clk = 1'b0;
        end

        always #50 clk = ~clk;

        always @(posedge clk)
        begin
                cycles <= cycles + 1;
                if (cycles > CYCLE_LIMIT)
                begin
                        $display("Timeout, the run went past %0d cycles.", CYCLE_LIMIT);
                        $display("TEST RESULT: FAIL");
                        $fatal(1, "Simulation stopped by the cycle limit.");
                end
        end

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (expected !== actual)
                begin
                        $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
                        $display("TEST RESULT: FAIL");
                        $fatal(1, "Mismatch on %s.", name);
                end
        endtask

        // Write data for random rows is drawn here and kept for the read checks.
        task automatic apply_row(input row_t row);
                stall         = row.stall;
                alu_clear     = row.clear;
                alu_pc        = row.alu_pc;
                exc           = row.exc;
                pc_buf        = row.pc_buf;
                wr.valid      = row.wr.valid;
                wr.index_0    = row.wr.index_0;
                wr.index_1    = row.wr.index_1;
                wr.flags      = row.wr.flags;
                wr.flag_update = row.wr.flag_update;
                wr.data_0     = row.wr.data_0;
                wr.data_1     = row.wr.data_1;
                if (row.wr.rnd)
                begin
                        rand_0    = $random(seed);
                        rand_1    = $random(seed);
                        wr.data_0 = rand_0;
                        wr.data_1 = rand_1;
                end
                for (int p = 0; p < 4; p++)
                        rd_index[p] = row.rd_index[p];
        endtask

        function automatic logic [31:0] expected_read(input row_t row, input int p);
                case (row.rd_sel[p])
                        2'd1:    return rand_0;
                        2'd2:    return rand_1;
                        default: return row.exp_rd[p];
                endcase
        endfunction

        task automatic check_pulses(input row_t row);
                check_value("o_clear_from_writeback", 32'(row.exp_flush), 32'(flush));
                check_value("o_fiq_ack", 32'(row.exp_fiq), 32'(fiq_ack));
                check_value("o_irq_ack", 32'(row.exp_irq), 32'(irq_ack));
        endtask

        task automatic check_state(input row_t row);
                check_value("o_pc", row.exp_pc, pc);
                check_value("o_cpsr", row.exp_cpsr, cpsr);
                for (int p = 0; p < 4; p++)
                        check_value($sformatf("o_rd_data_%0d", p), expected_read(row, p),
                                    rd_data[p]);
        endtask

        initial
        begin
                reset     = 1'b1;
                stall     = '0;
                alu_clear = 1'b0;
                alu_pc    = '0;
                exc       = '0;
                wr        = '0;
                pc_buf    = '0;
                rand_0    = '0;
                rand_1    = '0;
                for (int p = 0; p < 4; p++)
                        rd_index[p] = phy_reg_t'(p);
                vectors   = '{32'h10, 32'h1c, 32'h18, 32'h0c, 32'h08, 32'h04};

                repeat (RESET_CYCLES) @(posedge clk);
                #1 reset = 1'b0;

                // Reset state, with no request pending.
                check_value("o_pc", 32'h0, pc);
                check_value("o_cpsr", 32'h13, cpsr);
                for (int p = 0; p < 4; p++)
                        check_value($sformatf("o_rd_data_%0d", p), 32'h0, rd_data[p]);
                check_value("o_clear_from_writeback", 32'h0, 32'(flush));
                check_value("o_fiq_ack", 32'h0, 32'(fiq_ack));
                check_value("o_irq_ack", 32'h0, 32'(irq_ack));

                for (int r = 0; r < NUM_ROWS; r++)
                begin
                        apply_row(rows[r]);
                        #49;
                        check_pulses(rows[r]);
                        @(posedge clk);
                        #1;
                        check_state(rows[r]);
                end

                $display("TEST RESULT: PASS");
                $finish;
        end

endmodule

// ==== design/writeback_unit.sv ====
module writeback_unit #(
        parameter int PHY_REGS = cpu_arch_pkg::MIN_PHY_REGS
)
(
        input  logic                       i_clk,
        input  logic                       i_reset,
        input  wb_port_pkg::stall_t        i_stall,
        input  logic                       i_alu_clear,
        input  logic [31:0]                i_alu_pc,
        input  wb_port_pkg::exc_req_t      i_exc,
        input  wb_port_pkg::vector_table_t i_vectors,
        input  wb_port_pkg::wr_req_t       i_wr,
        input  logic [31:0]                i_pc_buf,
        input  cpu_arch_pkg::phy_reg_t     i_rd_index_0,
        input  cpu_arch_pkg::phy_reg_t     i_rd_index_1,
        input  cpu_arch_pkg::phy_reg_t     i_rd_index_2,
        input  cpu_arch_pkg::phy_reg_t     i_rd_index_3,
        output logic [31:0]                o_rd_data_0,
        output logic [31:0]                o_rd_data_1,
        output logic [31:0]                o_rd_data_2,
        output logic [31:0]                o_rd_data_3,
        output logic [31:0]                o_pc,
        output cpu_arch_pkg::cpsr_t        o_cpsr,
        output logic                       o_clear_from_writeback,
        output logic                       o_fiq_ack,
        output logic                       o_irq_ack
);
        import cpu_arch_pkg::*;

        logic [31:0] seq_pc;
        logic        exc_taken;
        logic [31:0] exc_pc;
        phy_reg_t    link_index;
        logic [31:0] link_value;
        phy_reg_t    spsr_index;
        cpu_mode_t   new_mode;

        pc_sequencer i_pc_sequencer (
                .i_stall     (i_stall),
                .i_alu_clear (i_alu_clear),
                .i_alu_pc    (i_alu_pc),
                .i_pc        (o_pc),
                .i_thumb     (o_cpsr.t),
                .o_seq_pc    (seq_pc)
        );

        exception_entry i_exception_entry (
                .i_exc        (i_exc),
                .i_vectors    (i_vectors),
                .i_pc_buf     (i_pc_buf),
                .o_taken      (exc_taken),
                .o_exc_pc     (exc_pc),
                .o_link_index (link_index),
                .o_link_value (link_value),
                .o_spsr_index (spsr_index),
                .o_new_mode   (new_mode),
                .o_fiq_ack    (o_fiq_ack),
                .o_irq_ack    (o_irq_ack)
        );

        banked_register_file #(
                .PHY_REGS (PHY_REGS)
        ) i_banked_register_file (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_wr         (i_wr),
                .i_pc_buf     (i_pc_buf),
                .i_seq_pc     (seq_pc),
                .i_exc_taken  (exc_taken),
                .i_exc_pc     (exc_pc),
                .i_link_index (link_index),
                .i_link_value (link_value),
                .i_spsr_index (spsr_index),
                .i_new_mode   (new_mode),
                .i_rd_index_0 (i_rd_index_0),
                .i_rd_index_1 (i_rd_index_1),
                .i_rd_index_2 (i_rd_index_2),
                .i_rd_index_3 (i_rd_index_3),
                .o_rd_data_0  (o_rd_data_0),
                .o_rd_data_1  (o_rd_data_1),
                .o_rd_data_2  (o_rd_data_2),
                .o_rd_data_3  (o_rd_data_3),
                .o_pc         (o_pc),
                .o_cpsr       (o_cpsr),
                .o_flush      (o_clear_from_writeback)
        );

endmodule

// ==== design/banked_register_file.sv ====
module banked_register_file #(
        parameter int PHY_REGS = cpu_arch_pkg::MIN_PHY_REGS
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  wb_port_pkg::wr_req_t    i_wr,
        input  logic [31:0]             i_pc_buf,
        input  logic [31:0]             i_seq_pc,
        input  logic                    i_exc_taken,
        input  logic [31:0]             i_exc_pc,
        input  cpu_arch_pkg::phy_reg_t  i_link_index,
        input  logic [31:0]             i_link_value,
        input  cpu_arch_pkg::phy_reg_t  i_spsr_index,
        input  cpu_arch_pkg::cpu_mode_t i_new_mode,
        input  cpu_arch_pkg::phy_reg_t  i_rd_index_0,
        input  cpu_arch_pkg::phy_reg_t  i_rd_index_1,
        input  cpu_arch_pkg::phy_reg_t  i_rd_index_2,
        input  cpu_arch_pkg::phy_reg_t  i_rd_index_3,
        output logic [31:0]             o_rd_data_0,
        output logic [31:0]             o_rd_data_1,
        output logic [31:0]             o_rd_data_2,
        output logic [31:0]             o_rd_data_3,
        output logic [31:0]             o_pc,
        output cpu_arch_pkg::cpsr_t     o_cpsr,
        output logic                    o_flush
);
        import cpu_arch_pkg::*;

        logic [31:0] r_ff  [PHY_REGS];
        logic [31:0] r_nxt [PHY_REGS];
        cpsr_t       cpsr_q;

        assign cpsr_q = r_ff[PHY_CPSR];

        // Read ports, straight from state.
        assign o_rd_data_0 = r_ff[i_rd_index_0];
        assign o_rd_data_1 = r_ff[i_rd_index_1];
        assign o_rd_data_2 = r_ff[i_rd_index_2];
        assign o_rd_data_3 = r_ff[i_rd_index_3];
        assign o_pc        = r_ff[PHY_PC];
        assign o_cpsr      = cpsr_q;

        always_comb
        begin
                cpsr_t cpsr_d;

                r_nxt         = r_ff;
                r_nxt[PHY_PC] = i_seq_pc;
                cpsr_d        = cpsr_q;
                o_flush       = 1'b0;

                if (i_exc_taken)
                begin
                        // Atomic entry overrides stalls and the retiring write.
                        o_flush             = 1'b1;
                        r_nxt[PHY_PC]       = i_exc_pc;
                        r_nxt[i_link_index] = i_link_value;
                        r_nxt[i_spsr_index] = cpsr_q;
                        cpsr_d.mode         = i_new_mode;
                end
                else if (i_wr.valid)
                begin
                        // Port 1 goes last, so it wins a same-index collision.
                        r_nxt[PHY_CPSR][31:28] = i_wr.flags;
                        r_nxt[i_wr.index_0]    = i_wr.data_0;
                        r_nxt[i_wr.index_1]    = i_wr.data_1;
                        cpsr_d                 = r_nxt[PHY_CPSR];

                        if (cpsr_q.mode == USR)
                        begin
                                // User code may not touch masks or mode.
                                cpsr_d[7:0] = cpsr_q[7:0];
                        end
                        else if (cpsr_d[7:0] != cpsr_q[7:0])
                        begin
                                // Mode or mask change, refetch from the next instruction.
                                o_flush       = 1'b1;
                                r_nxt[PHY_PC] = i_pc_buf - 32'd4;
                        end

                        cpsr_d.t = r_nxt[PHY_PC][0];

                        if (i_wr.index_0 == ARCH_PC)
                        begin
                                o_flush = 1'b1;
                                if (i_wr.flag_update)
                                begin
                                        // Exception return. USR has no SPSR to restore.
                                        case (cpsr_q.mode)
                                                FIQ:     cpsr_d = r_ff[PHY_FIQ_SPSR];
                                                IRQ:     cpsr_d = r_ff[PHY_IRQ_SPSR];
                                                SVC:     cpsr_d = r_ff[PHY_SVC_SPSR];
                                                ABT:     cpsr_d = r_ff[PHY_ABT_SPSR];
                                                UND:     cpsr_d = r_ff[PHY_UND_SPSR];
                                                default: cpsr_d = cpsr_d;
                                        endcase
                                end
                        end
                end

                r_nxt[PHY_CPSR] = cpsr_d;
        end

        // Core comes out of reset at address 0 in supervisor mode.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < PHY_REGS; i++)
                                r_ff[i] <= '0;
                        r_ff[PHY_CPSR] <= 32'(SVC);
                end
                else
                begin
                        r_ff <= r_nxt;
                end
        end

endmodule

// ==== design/exception_entry.sv ====
module exception_entry
(
        input  wb_port_pkg::exc_req_t      i_exc,
        input  wb_port_pkg::vector_table_t i_vectors,
        input  logic [31:0]                i_pc_buf,
        output logic                       o_taken,
        output logic [31:0]                o_exc_pc,
        output cpu_arch_pkg::phy_reg_t     o_link_index,
        output logic [31:0]                o_link_value,
        output cpu_arch_pkg::phy_reg_t     o_spsr_index,
        output cpu_arch_pkg::cpu_mode_t    o_new_mode,
        output logic                       o_fiq_ack,
        output logic                       o_irq_ack
);
        import cpu_arch_pkg::*;

        logic link_minus_4;

        // Priority encoder. Undefined is the lowest entry and serves as the default.
        always_comb
        begin
                o_taken      = 1'b1;
                o_exc_pc     = i_vectors.und;
                o_link_index = PHY_UND_R14;
                o_spsr_index = PHY_UND_SPSR;
                o_new_mode   = UND;
                link_minus_4 = 1'b1;
                o_fiq_ack    = 1'b0;
                o_irq_ack    = 1'b0;

                if (i_exc.data_abt)
                begin
                        // Handler returns with LR - 8 to retry the access.
                        o_exc_pc     = i_vectors.data_abt;
                        o_link_index = PHY_ABT_R14;
                        o_spsr_index = PHY_ABT_SPSR;
                        o_new_mode   = ABT;
                        link_minus_4 = 1'b0;
                end
                else if (i_exc.fiq)
                begin
                        o_exc_pc     = i_vectors.fiq;
                        o_link_index = PHY_FIQ_R14;
                        o_spsr_index = PHY_FIQ_SPSR;
                        o_new_mode   = FIQ;
                        o_fiq_ack    = 1'b1;
                end
                else if (i_exc.irq)
                begin
                        o_exc_pc     = i_vectors.irq;
                        o_link_index = PHY_IRQ_R14;
                        o_spsr_index = PHY_IRQ_SPSR;
                        o_new_mode   = IRQ;
                        o_irq_ack    = 1'b1;
                end
                else if (i_exc.instr_abt)
                begin
                        o_exc_pc     = i_vectors.instr_abt;
                        o_link_index = PHY_ABT_R14;
                        o_spsr_index = PHY_ABT_SPSR;
                        o_new_mode   = ABT;
                end
                else if (i_exc.swi)
                begin
                        o_exc_pc     = i_vectors.swi;
                        o_link_index = PHY_SVC_R14;
                        o_spsr_index = PHY_SVC_SPSR;
                        o_new_mode   = SVC;
                end
                else if (!i_exc.und)
                begin
                        o_taken = 1'b0;
                end
        end

        // PC + 8 minus 4 points at the instruction after the faulting one.
        assign o_link_value = link_minus_4 ? i_pc_buf - 32'd4 : i_pc_buf;

endmodule

// ==== design/pc_sequencer.sv ====
module pc_sequencer
(
        input  wb_port_pkg::stall_t i_stall,
        input  logic                i_alu_clear,
        input  logic [31:0]         i_alu_pc,
        input  logic [31:0]         i_pc,
        input  logic                i_thumb,
        output logic [31:0]         o_seq_pc
);

        logic late_stall;

        // Stalls from the later stages sit below the ALU redirect.
        assign late_stall = i_stall.decode | i_stall.issue | i_stall.shifter;

        always_comb
        begin
                if (i_stall.code || i_stall.data)
                begin
                        // Memory stalls freeze everything, a redirect included.
                        o_seq_pc = i_pc;
                end
                else if (i_alu_clear)
                begin
                        o_seq_pc = i_alu_pc;
                end
                else if (late_stall)
                begin
                        o_seq_pc = i_pc;
                end
                else
                begin
                        // Halfword steps in Thumb state, word steps in ARM state.
                        o_seq_pc = i_pc + (i_thumb ? 32'd2 : 32'd4);
                end
        end

endmodule

// ==== design/wb_port_pkg.sv ====
package wb_port_pkg;

        // Sources that can freeze the PC.
        typedef struct packed {
                logic code;
                logic data;
                logic decode;
                logic issue;
                logic shifter;
        } stall_t;

        // Pending exceptions, highest priority first.
        typedef struct packed {
                logic data_abt;
                logic fiq;
                logic irq;
                logic instr_abt;
                logic swi;
                logic und;
        } exc_req_t;

        // One vector per exception, same order as exc_req_t.
        typedef struct packed {
                logic [31:0] data_abt;
                logic [31:0] fiq;
                logic [31:0] irq;
                logic [31:0] instr_abt;
                logic [31:0] swi;
                logic [31:0] und;
        } vector_table_t;

        // Retiring instruction: two register writes plus the flag result.
        typedef struct packed {
                logic                   valid;
                cpu_arch_pkg::phy_reg_t index_0;
                logic [31:0]            data_0;
                cpu_arch_pkg::phy_reg_t index_1;
                logic [31:0]            data_1;
                logic [3:0]             flags;
                logic                   flag_update;
        } wr_req_t;

endpackage

// ==== design/cpu_arch_pkg.sv ====
package cpu_arch_pkg;

        // Processor modes as encoded in CPSR[4:0].
        typedef enum logic [4:0] {
                USR = 5'h10,
                FIQ = 5'h11,
                IRQ = 5'h12,
                SVC = 5'h13,
                ABT = 5'h17,
                UND = 5'h1b
        } cpu_mode_t;

        // Control byte is bits 7 to 0 (masks, T bit and mode).
        typedef struct packed {
                logic [3:0]  flags;     // N Z C V
                logic [19:0] reserved;
                logic        irq_dis;
                logic        fiq_dis;
                logic        t;
                cpu_mode_t   mode;
        } cpsr_t;

        // Index into the physical register array.
        typedef logic [5:0] phy_reg_t;

        // Physical layout.
        // 0 to 15 are the user set, 16 is the CPSR, 17 to 23 the FIQ bank,
        // then R13 and R14 pairs for IRQ, SVC, ABT and UND.
        // SPSRs follow at 32 to 36; 37 upwards is scratch for the issue stage.
        localparam phy_reg_t ARCH_PC      = 6'd15;
        localparam phy_reg_t PHY_PC       = ARCH_PC;
        localparam phy_reg_t PHY_CPSR     = 6'd16;
        localparam phy_reg_t PHY_FIQ_R14  = 6'd23;
        localparam phy_reg_t PHY_IRQ_R14  = 6'd25;
        localparam phy_reg_t PHY_SVC_R14  = 6'd27;
        localparam phy_reg_t PHY_ABT_R14  = 6'd29;
        localparam phy_reg_t PHY_UND_R14  = 6'd31;
        localparam phy_reg_t PHY_FIQ_SPSR = 6'd32;
        localparam phy_reg_t PHY_IRQ_SPSR = 6'd33;
        localparam phy_reg_t PHY_SVC_SPSR = 6'd34;
        localparam phy_reg_t PHY_ABT_SPSR = 6'd35;
        localparam phy_reg_t PHY_UND_SPSR = 6'd36;

        localparam int MIN_PHY_REGS = 46;

endpackage
